/* include/rr_arb_defs.svh */
`ifndef RR_ARB_DEFS_SVH
`define RR_ARB_DEFS_SVH

// ----------------------------------------------------------------------
// Datapath

// Token width, source tag plus count
`define DATA_W      4

// Entries per source FIFO
`define FIFO_DEPTH  4

// ----------------------------------------------------------------------
// Display

`define NUM_DIGITS  4

// Prescaler width, one digit step every 2**SCAN_DIV_W clocks
`define SCAN_DIV_W  10

`endif

/* hw/rr_arb_pkg.sv */
`include "rr_arb_defs.svh"

package rr_arb_pkg;

    // ------------------------------------------------------------------
    // Vector types

    typedef logic [`DATA_W     - 1:0] data_t;       // Tag bit plus count
    typedef logic [`DATA_W     - 2:0] count_t;
    typedef logic [              7:0] seg_t;        // a is the MSB, h the LSB
    typedef logic [`NUM_DIGITS - 1:0] digit_sel_t;  // One-hot

    // Arbiter favours this head when both are valid
    typedef enum logic
    {
        PRIO_A = 1'b0,
        PRIO_B = 1'b1
    } prio_e;

    // ------------------------------------------------------------------
    // Display bundles

    typedef struct packed
    {
        logic a_ready;
        logic b_ready;
        logic out_ready;
        logic out_valid;
    } flow_status_s;

    typedef struct packed
    {
        data_t        a_data;
        data_t        b_data;
        data_t        out_data;
        flow_status_s status;
    } display_in_s;

endpackage

/* hw/token_counter.sv */
`timescale 1ns/1ns

module token_counter
    import rr_arb_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    input  logic  valid,
    input  logic  ready,   // in_ready of the receiving FIFO
    input  logic  tag,     // Source bit, MSB of every token
    output data_t data
);

    count_t count;
    logic   xfer;

    assign xfer = valid & ready;

    // Next token advances after each accepted one, wraps naturally
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            count <= '0;
        end
        else if (xfer)
        begin
            count <= count + 1'b1;
        end
    end

    assign data = {tag, count};  // A gives 0..7, B gives 8..f

endmodule

/* hw/sync_fifo.sv */
`timescale 1ns/1ns

module sync_fifo
    import rr_arb_pkg::*;
#(
    parameter depth = 4
)
(
    input  logic  clk,
    input  logic  rst_n,

    input  logic  in_valid,
    output logic  in_ready,
    input  data_t in_data,

    output logic  out_valid,
    input  logic  out_ready,
    output data_t out_data
);

    localparam ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam cnt_w = $clog2(depth + 1);

    localparam [ptr_w - 1:0] last_ptr = ptr_w'(depth - 1);
    localparam [cnt_w - 1:0] full_cnt = cnt_w'(depth);

    data_t              mem [depth];
    logic [ptr_w - 1:0] wr_ptr;
    logic [ptr_w - 1:0] rd_ptr;
    logic [cnt_w - 1:0] count;   // Occupancy

    logic push;
    logic pop;
    logic full;
    logic empty;

    // ------------------------------------------------------------------
    // Flags and head

    assign full  = (count == full_cnt);
    assign empty = (count == '0);

    assign in_ready  = ~full;         // State only, never from in_valid
    assign out_valid = ~empty;
    assign out_data  = mem[rd_ptr];   // Written entry shows up next cycle

    assign push = in_valid  & in_ready;
    assign pop  = out_valid & out_ready;

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    // ------------------------------------------------------------------
    // Pointers and occupancy

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;

            if (pop)
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;

            case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Idle or push with pop
            endcase
        end
    end

    // A push never lands on an unread entry
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push && !empty |-> wr_ptr != rd_ptr);

    // A pop always reads a written entry
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop && !full |-> wr_ptr != rd_ptr);

    // Stalled head must not change under a concurrent push
    a_head_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

/* hw/rr_arbiter_2.sv */
`timescale 1ns/1ns

module rr_arbiter_2
    import rr_arb_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    input  logic  a_valid,
    output logic  a_ready,
    input  data_t a_data,

    input  logic  b_valid,
    output logic  b_ready,
    input  data_t b_data,

    output logic  out_valid,
    input  logic  out_ready,
    output data_t out_data
);

    prio_e prio;
    logic  hold;      // Output stalled in the last cycle
    logic  hold_a;    // Grant kept through the stall
    logic  grant_a;
    logic  grant_b;

    // ------------------------------------------------------------------
    // Grant

    // A stalled output keeps its head
    // Otherwise a lone valid head wins regardless of priority
    assign grant_a = a_valid & (hold ? hold_a  : (~b_valid | (prio == PRIO_A)));
    assign grant_b = b_valid & (hold ? ~hold_a : (~a_valid | (prio == PRIO_B)));

    assign out_valid = grant_a | grant_b;
    assign out_data  = grant_a ? a_data : b_data;

    // Only the granted FIFO sees out_ready
    assign a_ready = grant_a & out_ready;
    assign b_ready = grant_b & out_ready;

    // Priority flips to the other side after every output transfer
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            prio   <= PRIO_A;
            hold   <= 1'b0;
            hold_a <= 1'b0;
        end
        else
        begin
            hold   <= out_valid & ~out_ready;
            hold_a <= grant_a;

            if (out_valid & out_ready)
                prio <= grant_a ? PRIO_B : PRIO_A;
        end
    end

    a_one_ready: assert property (@(posedge clk) disable iff (!rst_n)
        !(a_ready && b_ready));

    // Held grant still points at a valid head
    a_grant_valid: assert property (@(posedge clk) disable iff (!rst_n)
        hold |-> (hold_a ? a_valid : b_valid));

endmodule

/* hw/seg7_scanner.sv */
`timescale 1ns/1ns
`include "rr_arb_defs.svh"

module seg7_scanner
    import rr_arb_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  display_in_s disp,
    output seg_t        abcdefgh,
    output digit_sel_t  digit
);

    localparam seg_t seg_blank     = 8'b0000_0000;
    localparam seg_t seg_ready_a   = 8'b1000_0000;  // Segment a
    localparam seg_t seg_ready_b   = 8'b0000_0010;  // Segment g
    localparam seg_t seg_ready_out = 8'b0001_0000;  // Segment d

    // Scan order out, status, B, A
    localparam digit_sel_t dig_out    = digit_sel_t'(1);
    localparam digit_sel_t dig_status = digit_sel_t'(2);
    localparam digit_sel_t dig_b      = digit_sel_t'(4);
    localparam digit_sel_t dig_a      = digit_sel_t'(8);

    logic [`SCAN_DIV_W - 1:0] scan_cnt;
    logic                     scan_tick;
    seg_t                     status_seg;

    function automatic seg_t hex_to_seg(input data_t value);
        seg_t seg;
        case (value)
        4'h0:    seg = 8'b1111_1100;
        4'h1:    seg = 8'b0110_0000;
        4'h2:    seg = 8'b1101_1010;
        4'h3:    seg = 8'b1111_0010;
        4'h4:    seg = 8'b0110_0110;
        4'h5:    seg = 8'b1011_0110;
        4'h6:    seg = 8'b1011_1110;
        4'h7:    seg = 8'b1110_0000;
        4'h8:    seg = 8'b1111_1110;
        4'h9:    seg = 8'b1111_0110;
        4'ha:    seg = 8'b1110_1110;
        4'hb:    seg = 8'b0011_1110;
        4'hc:    seg = 8'b1001_1100;
        4'hd:    seg = 8'b0111_1010;
        4'he:    seg = 8'b1001_1110;
        4'hf:    seg = 8'b1000_1110;
        default: seg = seg_blank;
        endcase
        return seg;
    endfunction

    // ------------------------------------------------------------------
    // Digit scan

    assign scan_tick = &scan_cnt;   // Last prescaler count

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            scan_cnt <= '0;
            digit    <= dig_out;
        end
        else
        begin
            scan_cnt <= scan_cnt + 1'b1;

            if (scan_tick)
                digit <= {digit[`NUM_DIGITS - 2:0], digit[`NUM_DIGITS - 1]};
        end
    end

    // ------------------------------------------------------------------
    // Segment select

    always_comb
    begin
        status_seg = seg_blank;

        if (disp.status.a_ready)   status_seg |= seg_ready_a;
        if (disp.status.b_ready)   status_seg |= seg_ready_b;
        if (disp.status.out_ready) status_seg |= seg_ready_out;
    end

    always_comb
    begin
        case (digit)
        dig_out:    abcdefgh = disp.status.out_valid ? hex_to_seg(disp.out_data) : seg_blank;
        dig_status: abcdefgh = status_seg;
        dig_b:      abcdefgh = hex_to_seg(disp.b_data);
        dig_a:      abcdefgh = hex_to_seg(disp.a_data);
        default:    abcdefgh = seg_blank;
        endcase
    end

    // Digit holds for the whole prescaler period
    a_digit_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !scan_tick |=> $stable(digit) && $onehot(digit));

endmodule

/* hw/rr_fifo_arbiter_top.sv */
`timescale 1ns/1ns
`include "rr_arb_defs.svh"

module rr_fifo_arbiter_top
    import rr_arb_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       a_valid,
    output logic       a_ready,
    input  logic       b_valid,
    output logic       b_ready,

    output logic       out_valid,
    input  logic       out_ready,
    output data_t      out_data,

    output seg_t       abcdefgh,
    output digit_sel_t digit
);

    data_t       a_token;       // Next token from source A
    data_t       b_token;
    data_t       a_head;
    data_t       b_head;
    logic        a_head_valid;
    logic        a_head_ready;
    logic        b_head_valid;
    logic        b_head_ready;
    display_in_s disp;

    // ------------------------------------------------------------------
    // Sources and their FIFOs

    token_counter i_a_counter
    (
        .clk   (clk),
        .rst_n (rst_n),
        .valid (a_valid),
        .ready (a_ready),
        .tag   (1'b0),
        .data  (a_token)
    );

    token_counter i_b_counter
    (
        .clk   (clk),
        .rst_n (rst_n),
        .valid (b_valid),
        .ready (b_ready),
        .tag   (1'b1),
        .data  (b_token)
    );

    sync_fifo #(.depth (`FIFO_DEPTH)) i_a_fifo
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (a_valid),
        .in_ready  (a_ready),
        .in_data   (a_token),
        .out_valid (a_head_valid),
        .out_ready (a_head_ready),
        .out_data  (a_head)
    );

    sync_fifo #(.depth (`FIFO_DEPTH)) i_b_fifo
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (b_valid),
        .in_ready  (b_ready),
        .in_data   (b_token),
        .out_valid (b_head_valid),
        .out_ready (b_head_ready),
        .out_data  (b_head)
    );

    // ------------------------------------------------------------------
    // Merge and display

    rr_arbiter_2 i_arbiter
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .a_valid   (a_head_valid),
        .a_ready   (a_head_ready),
        .a_data    (a_head),
        .b_valid   (b_head_valid),
        .b_ready   (b_head_ready),
        .b_data    (b_head),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    assign disp.a_data           = a_token;
    assign disp.b_data           = b_token;
    assign disp.out_data         = out_data;
    assign disp.status.a_ready   = a_ready;
    assign disp.status.b_ready   = b_ready;
    assign disp.status.out_ready = out_ready;
    assign disp.status.out_valid = out_valid;

    seg7_scanner i_scanner
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .disp     (disp),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

endmodule

/* verif/tb_rr_fifo_arbiter.sv */
`timescale 1ns/1ns
`include "rr_arb_defs.svh"

module tb_rr_fifo_arbiter
    import rr_arb_pkg::*;
;

    logic       clk;
    logic       rst_n;
    logic       a_valid;
    logic       a_ready;
    logic       b_valid;
    logic       b_ready;
    logic       out_valid;
    logic       out_ready;
    data_t      out_data;
    seg_t       abcdefgh;
    digit_sel_t digit;

    logic [31:0] rand_state;
    int          error_count;

    // Model state, updated once per cycle at the falling edge
    data_t                    qa[$];
    data_t                    qb[$];
    count_t                   a_cnt;
    count_t                   b_cnt;
    count_t                   next_a_out;   // Expected order at the output
    count_t                   next_b_out;
    prio_e                    prio;
    logic [`SCAN_DIV_W - 1:0] scan_cnt;
    digit_sel_t               scan_digit;
    logic                     stall_prev;
    logic                     stall_grant_a;
    data_t                    stall_data;
    int                       a_pushed;
    int                       a_popped;
    int                       b_pushed;
    int                       b_popped;
    logic                     out_hex_seen;
    logic                     status_seen;

    rr_fifo_arbiter_top i_dut
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .a_valid   (a_valid),
        .a_ready   (a_ready),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .abcdefgh  (abcdefgh),
        .digit     (digit)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Helpers and reference functions

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic chance(input logic [31:0] state, input int pct);
        return ((state >> 16) % 100) < pct;
    endfunction

    // Segment a is bit 7 down to g at bit 1, dot unused
    function automatic seg_t hex_segments(input data_t value);
        case (value)
        4'h0:    return 8'b1111_1100;
        4'h1:    return 8'b0110_0000;
        4'h2:    return 8'b1101_1010;
        4'h3:    return 8'b1111_0010;
        4'h4:    return 8'b0110_0110;
        4'h5:    return 8'b1011_0110;
        4'h6:    return 8'b1011_1110;
        4'h7:    return 8'b1110_0000;
        4'h8:    return 8'b1111_1110;
        4'h9:    return 8'b1111_0110;
        4'ha:    return 8'b1110_1110;
        4'hb:    return 8'b0011_1110;
        4'hc:    return 8'b1001_1100;
        4'hd:    return 8'b0111_1010;
        4'he:    return 8'b1001_1110;
        default: return 8'b1000_1110;
        endcase
    endfunction

    function automatic logic pick_a(input int a_size, input int b_size, input prio_e p);
        return (a_size > 0) && ((b_size == 0) || (p == PRIO_A));
    endfunction

    function automatic seg_t expected_display(input digit_sel_t dig, input display_in_s d);
        seg_t seg;
        seg = 8'h00;
        if (dig == digit_sel_t'(1))
        begin
            if (d.status.out_valid)
                seg = hex_segments(d.out_data);   // Blank otherwise
        end
        else if (dig == digit_sel_t'(2))
        begin
            if (d.status.a_ready)   seg = seg | 8'b1000_0000;
            if (d.status.b_ready)   seg = seg | 8'b0000_0010;
            if (d.status.out_ready) seg = seg | 8'b0001_0000;
        end
        else if (dig == digit_sel_t'(4))
            seg = hex_segments(d.b_data);
        else if (dig == digit_sel_t'(8))
            seg = hex_segments(d.a_data);
        return seg;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("[ERROR] %0t %s: expected %0h, actual %0h", $time, name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("Finished with errors");
        $fatal(1, "wait timed out");
    endtask

    // ------------------------------------------------------------------
    // Compare process, inputs and outputs are settled at the falling edge

    always @(negedge clk)
    begin : compare_proc
        logic        exp_a_ready;
        logic        exp_b_ready;
        logic        exp_out_valid;
        logic        grant_a;
        data_t       exp_out_data;
        display_in_s disp_exp;

        if (!rst_n)
        begin
            qa.delete();
            qb.delete();
            a_cnt         = '0;
            b_cnt         = '0;
            next_a_out    = '0;
            next_b_out    = '0;
            prio          = PRIO_A;
            scan_cnt      = '0;
            scan_digit    = digit_sel_t'(1);
            stall_prev    = 1'b0;
            stall_grant_a = 1'b0;
        end
        else
        begin
            exp_a_ready   = qa.size() < `FIFO_DEPTH;   // Low exactly when full
            exp_b_ready   = qb.size() < `FIFO_DEPTH;
            exp_out_valid = (qa.size() > 0) || (qb.size() > 0);

            // Stalled output keeps the head it showed
            if (stall_prev)
                grant_a = stall_grant_a;
            else
                grant_a = pick_a(qa.size(), qb.size(), prio);
            exp_out_data  = grant_a ? qa[0] : ((qb.size() > 0) ? qb[0] : '0);

            check_value("a_ready", 32'(exp_a_ready), 32'(a_ready));
            check_value("b_ready", 32'(exp_b_ready), 32'(b_ready));
            check_value("out_valid", 32'(exp_out_valid), 32'(out_valid));
            if (exp_out_valid)
                check_value("out_data", 32'(exp_out_data), 32'(out_data));

            // Stalled output holds its token
            if (stall_prev)
            begin
                check_value("out_valid under stall", 32'(1), 32'(out_valid));
                check_value("out_data under stall", 32'(stall_data), 32'(out_data));
            end

            disp_exp.a_data           = {1'b0, a_cnt};
            disp_exp.b_data           = {1'b1, b_cnt};
            disp_exp.out_data         = exp_out_data;
            disp_exp.status.a_ready   = exp_a_ready;
            disp_exp.status.b_ready   = exp_b_ready;
            disp_exp.status.out_ready = out_ready;
            disp_exp.status.out_valid = exp_out_valid;
            check_value("digit", 32'(scan_digit), 32'(digit));
            check_value("abcdefgh", 32'(expected_display(scan_digit, disp_exp)),
                        32'(abcdefgh));
            if (scan_digit == digit_sel_t'(1) && exp_out_valid)
                out_hex_seen = 1'b1;
            if (scan_digit == digit_sel_t'(2))
                status_seen = 1'b1;

            // Output transfer pops the granted head and flips priority
            if (exp_out_valid && out_ready)
            begin
                if (grant_a)
                begin
                    check_value("A token order", 32'({1'b0, next_a_out}), 32'(out_data));
                    next_a_out = next_a_out + 1'b1;
                    void'(qa.pop_front());
                    a_popped++;
                    prio = PRIO_B;
                end
                else
                begin
                    check_value("B token order", 32'({1'b1, next_b_out}), 32'(out_data));
                    next_b_out = next_b_out + 1'b1;
                    void'(qb.pop_front());
                    b_popped++;
                    prio = PRIO_A;
                end
            end

            if (a_valid && exp_a_ready)
            begin
                qa.push_back({1'b0, a_cnt});   // Visible at the head next cycle
                a_cnt = a_cnt + 1'b1;
                a_pushed++;
            end
            if (b_valid && exp_b_ready)
            begin
                qb.push_back({1'b1, b_cnt});
                b_cnt = b_cnt + 1'b1;
                b_pushed++;
            end

            stall_prev    = exp_out_valid && !out_ready;
            stall_grant_a = grant_a;
            stall_data    = exp_out_data;

            if (&scan_cnt)
                scan_digit = {scan_digit[`NUM_DIGITS - 2:0], scan_digit[`NUM_DIGITS - 1]};
            scan_cnt = scan_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus phases

    task automatic run_random(input int cycles, input int valid_pct, input int ready_pct);
        repeat (cycles)
        begin
            @(posedge clk);
            rand_state = lcg_next(rand_state);
            a_valid   <= chance(rand_state, valid_pct);
            rand_state = lcg_next(rand_state);
            b_valid   <= chance(rand_state, valid_pct);
            rand_state = lcg_next(rand_state);
            out_ready <= chance(rand_state, ready_pct);
        end
    endtask

    task automatic fill_under_backpressure();
        int waited;
        waited = 0;
        @(posedge clk);
        a_valid   <= 1'b1;
        b_valid   <= 1'b1;
        out_ready <= 1'b0;
        @(negedge clk);
        while (a_ready || b_ready)
        begin
            if (waited >= 4 * `FIFO_DEPTH + 8)
                timeout_fail("FIFOs did not fill while the output was stalled");
            @(negedge clk);
            waited++;
        end
        repeat (16) @(posedge clk);   // Hold the stall on full FIFOs
    endtask

    task automatic drain_output();
        int waited;
        waited = 0;
        @(posedge clk);
        a_valid   <= 1'b0;
        b_valid   <= 1'b0;
        out_ready <= 1'b1;
        @(negedge clk);
        while (out_valid)
        begin
            if (waited >= 4 * `FIFO_DEPTH + 8)
                timeout_fail("output did not drain after the sources stopped");
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
    endtask

    // ------------------------------------------------------------------
    // Main sequence

    initial
    begin
        rst_n        = 1'b0;
        a_valid      = 1'b0;
        b_valid      = 1'b0;
        out_ready    = 1'b0;
        rand_state   = 32'd10275;
        error_count  = 0;
        a_pushed     = 0;
        a_popped     = 0;
        b_pushed     = 0;
        b_popped     = 0;
        out_hex_seen = 1'b0;
        status_seen  = 1'b0;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check_value("out_valid after reset", 32'(0), 32'(out_valid));
        check_value("a_ready after reset", 32'(1), 32'(a_ready));
        check_value("b_ready after reset", 32'(1), 32'(b_ready));
        check_value("digit after reset", 32'(1), 32'(digit));
        check_value("out digit blank after reset", 32'(0), 32'(abcdefgh));

        run_random(3000, 70, 60);
        fill_under_backpressure();
        run_random(2500, 60, 80);
        drain_output();

        check_value("A queue empty", 32'(0), 32'(qa.size()));
        check_value("B queue empty", 32'(0), 32'(qb.size()));
        check_value("A tokens in vs out", 32'(a_pushed), 32'(a_popped));
        check_value("B tokens in vs out", 32'(b_pushed), 32'(b_popped));
        check_value("out digit with data seen", 32'(1), 32'(out_hex_seen));
        check_value("status digit seen", 32'(1), 32'(status_seen));

        if (error_count == 0)
        begin
            $display("Finished with no errors");
            $finish;
        end
        else
        begin
            $display("Finished with errors");
            $fatal(1, "checks failed");
        end
    end

endmodule

/* rr_fifo_arbiter.f */
+incdir+include
hw/rr_arb_pkg.sv
hw/token_counter.sv
hw/sync_fifo.sv
hw/rr_arbiter_2.sv
hw/seg7_scanner.sv
hw/rr_fifo_arbiter_top.sv
verif/tb_rr_fifo_arbiter.sv

/* Makefile */
# Verilator build and run for the round-robin FIFO arbiter

VERILATOR ?= verilator
FILELIST  ?= rr_fifo_arbiter.f
TB_TOP    ?= tb_rr_fifo_arbiter
RTL_TOP   ?= rr_fifo_arbiter_top
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --assert
PASS_TEXT ?= Finished with no errors

SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -j $(JOBS) --Mdir $(BUILD_DIR) \
		--top-module $(TB_TOP) -f $(FILELIST)

run: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
